/* Bender.yml */
package:
  name: timer

sources:
  - logic/timer_types_pkg.sv
  - logic/timer_reg_pkg.sv
  - logic/timer_cfg_if.sv
  - logic/timer_prescaler.sv
  - logic/timer_counter.sv
  - logic/timer_events.sv
  - logic/timer_regs.sv
  - logic/timer_top.sv
  - target: simulation
    files:
      - sim/timer_sva.sv
      - sim/timer_tb.sv

/* logic/timer_cfg_if.sv */
`timescale 1ns/100ps

interface timer_cfg_if #(
    parameter int DATA_WIDTH = 32
);
    typedef logic [DATA_WIDTH-1:0] data_t;

    logic  enable;
    logic  hold;
    data_t prescale;
    data_t reload;
    logic  load_strobe;
    data_t load_value;
    logic  tick;
    data_t value;
    logic  overflow;

    modport ctrl (
        output enable, hold, prescale, reload, load_strobe, load_value,
        input  value, overflow
    );

    modport presc (
        input  enable, hold, prescale,
        output tick
    );

    modport count (
        input  tick, reload, load_strobe, load_value,
        output value, overflow
    );

endinterface

/* logic/timer_counter.sv */
`timescale 1ns/100ps

module timer_counter #(
    parameter int DATA_WIDTH = 32
) (
    input  logic       seq,
    input  logic       reset,
    timer_cfg_if.count cfg
);
    typedef logic [DATA_WIDTH-1:0] data_t;

    data_t value_q;
    logic  overflow_q;

    always_ff @(posedge seq) begin
        if (reset) begin
            value_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            overflow_q <= 1'b0;
            // Software load wins over a tick in the same cycle
            if (cfg.load_strobe) begin
                value_q <= cfg.load_value;
            end else if (cfg.tick) begin
                if (value_q == cfg.reload) begin
                    value_q    <= '0;
                    overflow_q <= 1'b1;
                end else begin
                    value_q <= value_q + data_t'(1);
                end
            end
        end
    end

    assign cfg.value    = value_q;
    assign cfg.overflow = overflow_q;

endmodule

/* logic/timer_events.sv */
`timescale 1ns/100ps

module timer_events (
    input  logic seq,
    input  logic reset,
    input  logic overflow,
    input  logic irq_enable,
    input  logic clear_strobe,
    output logic er_value,
    output logic irq
);
    logic er_q;
    logic irq_q;

    always_ff @(posedge seq) begin
        if (reset) begin
            er_q  <= 1'b0;
            irq_q <= 1'b0;
        end else begin
            // A new event beats a clear in the same cycle
            er_q  <= overflow || (er_q && !clear_strobe);
            irq_q <= er_q && irq_enable;
        end
    end

    assign er_value = er_q;
    assign irq      = irq_q;

endmodule

/* logic/timer_prescaler.sv */
`timescale 1ns/100ps

module timer_prescaler #(
    parameter int DATA_WIDTH = 32
) (
    input  logic       seq,
    input  logic       reset,
    timer_cfg_if.presc cfg
);
    typedef logic [DATA_WIDTH-1:0] data_t;

    data_t count_q;
    data_t start;

    // Prescale of 0 acts as 1
    assign start = (cfg.prescale == '0) ? '0 : cfg.prescale - data_t'(1);

    always_ff @(posedge seq) begin
        if (reset) begin
            count_q <= '0;
        end else if (!cfg.enable) begin
            count_q <= start;
        end else if (!cfg.hold) begin
            if (count_q == '0) begin
                count_q <= start;
            end else begin
                count_q <= count_q - data_t'(1);
            end
        end
    end

    assign cfg.tick = cfg.enable && !cfg.hold && (count_q == '0);

endmodule

/* logic/timer_reg_pkg.sv */
package timer_reg_pkg;

    // Register map
    localparam timer_types_pkg::reg_offset_t CR_OFFSET  = 8'h00;
    localparam timer_types_pkg::reg_offset_t PR_OFFSET  = 8'h04;
    localparam timer_types_pkg::reg_offset_t VR_OFFSET  = 8'h08;
    localparam timer_types_pkg::reg_offset_t ARR_OFFSET = 8'h0C;
    localparam timer_types_pkg::reg_offset_t ER_OFFSET  = 8'h10;
    localparam timer_types_pkg::reg_offset_t IER_OFFSET = 8'h14;

    // Bit positions
    localparam int unsigned CR_ENABLE_BIT   = 0;
    localparam int unsigned ER_OVERFLOW_BIT = 0;

    // Reset values, truncated to the counter width where used
    localparam logic [63:0] PR_RESET  = 64'd1;
    localparam logic [63:0] ARR_RESET = '1;

endpackage

/* logic/timer_regs.sv */
`timescale 1ns/100ps

module timer_regs #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 32
) (
    input  logic                    seq,
    input  logic                    reset,
    input  logic [ADDR_WIDTH-1:0]   paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [DATA_WIDTH-1:0]   pwdata,
    input  logic [DATA_WIDTH/8-1:0] pstrb,
    output logic [DATA_WIDTH-1:0]   prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    pause_req,
    output logic                    pause_ack,
    input  logic                    er_value,
    output logic                    irq_enable,
    output logic                    clear_strobe,
    timer_cfg_if.ctrl               cfg
);
    typedef logic [DATA_WIDTH-1:0] data_t;

    localparam data_t PR_INIT  = data_t'(timer_reg_pkg::PR_RESET);
    localparam data_t ARR_INIT = data_t'(timer_reg_pkg::ARR_RESET);

    timer_types_pkg::apb_state_e   apb_state;
    timer_types_pkg::pause_state_e pause_state;
    timer_types_pkg::reg_offset_t  offset;

    logic  enable_q;
    logic  ier_q;
    data_t prescale_q;
    data_t reload_q;
    data_t rdata;
    logic  hit;
    logic  access;
    logic  wr_en;

    // Only the low byte selects a register, the base is decoded upstream
    assign offset = timer_types_pkg::reg_offset_t'(paddr[7:0]);

    always_ff @(posedge seq) begin
        if (reset) begin
            apb_state <= timer_types_pkg::IDLE;
        end else begin
            case (apb_state)
                timer_types_pkg::IDLE:
                    if (psel && !penable) apb_state <= timer_types_pkg::ACCESS;
                default:
                    apb_state <= timer_types_pkg::IDLE;
            endcase
        end
    end

    // Zero wait states
    assign access  = (apb_state == timer_types_pkg::ACCESS) && psel && penable;
    assign pready  = access;
    assign pslverr = access && !hit;

    // Full-word writes only, an empty strobe writes nothing
    assign wr_en = access && pwrite && hit && (pstrb != '0);

    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (offset)
            timer_reg_pkg::CR_OFFSET:  rdata[timer_reg_pkg::CR_ENABLE_BIT] = enable_q;
            timer_reg_pkg::PR_OFFSET:  rdata = prescale_q;
            timer_reg_pkg::VR_OFFSET:  rdata = cfg.value;
            timer_reg_pkg::ARR_OFFSET: rdata = reload_q;
            timer_reg_pkg::ER_OFFSET:  rdata[timer_reg_pkg::ER_OVERFLOW_BIT] = er_value;
            timer_reg_pkg::IER_OFFSET: rdata[timer_reg_pkg::ER_OVERFLOW_BIT] = ier_q;
            default:                   hit = 1'b0;
        endcase
    end

    assign prdata = rdata;

    always_ff @(posedge seq) begin
        if (reset) begin
            enable_q   <= 1'b0;
            prescale_q <= PR_INIT;
            reload_q   <= ARR_INIT;
            ier_q      <= 1'b0;
        end else if (wr_en) begin
            case (offset)
                timer_reg_pkg::CR_OFFSET:  enable_q <= pwdata[timer_reg_pkg::CR_ENABLE_BIT];
                timer_reg_pkg::PR_OFFSET:  prescale_q <= pwdata;
                timer_reg_pkg::ARR_OFFSET: reload_q <= pwdata;
                timer_reg_pkg::IER_OFFSET: ier_q <= pwdata[timer_reg_pkg::ER_OVERFLOW_BIT];
                default: ;
            endcase
        end
    end

    // Pause handshake, counting stays frozen through RESUME
    always_ff @(posedge seq) begin
        if (reset) begin
            pause_state <= timer_types_pkg::RUN;
        end else begin
            case (pause_state)
                timer_types_pkg::RUN:
                    if (pause_req) pause_state <= timer_types_pkg::PAUSED;
                timer_types_pkg::PAUSED:
                    if (!pause_req) pause_state <= timer_types_pkg::RESUME;
                default:
                    pause_state <= timer_types_pkg::RUN;
            endcase
        end
    end

    assign pause_ack = (pause_state == timer_types_pkg::PAUSED);

    assign cfg.enable      = enable_q;
    assign cfg.hold        = (pause_state != timer_types_pkg::RUN);
    assign cfg.prescale    = prescale_q;
    assign cfg.reload      = reload_q;
    assign cfg.load_strobe = wr_en && (offset == timer_reg_pkg::VR_OFFSET);
    assign cfg.load_value  = pwdata;

    // ER is write-one-to-clear
    assign clear_strobe = wr_en && (offset == timer_reg_pkg::ER_OFFSET)
                          && pwdata[timer_reg_pkg::ER_OVERFLOW_BIT];
    assign irq_enable   = ier_q;

endmodule

/* logic/timer_top.sv */
`timescale 1ns/100ps

module timer_top #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 32
) (
    input  logic                    seq,
    input  logic                    reset,
    input  logic [ADDR_WIDTH-1:0]   paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [DATA_WIDTH-1:0]   pwdata,
    input  logic [DATA_WIDTH/8-1:0] pstrb,
    output logic [DATA_WIDTH-1:0]   prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    pause_req,
    output logic                    pause_ack,
    output logic                    irq
);
    logic er_value;
    logic irq_enable;
    logic clear_strobe;

    timer_cfg_if #(.DATA_WIDTH(DATA_WIDTH)) cfg ();

    timer_regs #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_regs (
        .seq          (seq),
        .reset        (reset),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .pstrb        (pstrb),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .pause_req    (pause_req),
        .pause_ack    (pause_ack),
        .er_value     (er_value),
        .irq_enable   (irq_enable),
        .clear_strobe (clear_strobe),
        .cfg          (cfg.ctrl)
    );

    timer_prescaler #(.DATA_WIDTH(DATA_WIDTH)) i_prescaler (
        .seq   (seq),
        .reset (reset),
        .cfg   (cfg.presc)
    );

    timer_counter #(.DATA_WIDTH(DATA_WIDTH)) i_counter (
        .seq   (seq),
        .reset (reset),
        .cfg   (cfg.count)
    );

    timer_events i_events (
        .seq          (seq),
        .reset        (reset),
        .overflow     (cfg.overflow),
        .irq_enable   (irq_enable),
        .clear_strobe (clear_strobe),
        .er_value     (er_value),
        .irq          (irq)
    );

endmodule

/* logic/timer_types_pkg.sv */
package timer_types_pkg;

    // Byte offset of a register inside the peripheral window
    typedef logic [7:0] reg_offset_t;

    // Pause handshake with the power manager
    typedef enum logic [1:0] {
        RUN    = 2'd0,
        PAUSED = 2'd1,
        RESUME = 2'd2
    } pause_state_e;

    // APB slave phases, setup is taken in IDLE
    typedef enum logic {
        IDLE   = 1'b0,
        ACCESS = 1'b1
    } apb_state_e;

endpackage

/* sim/timer_sva.sv */
`timescale 1ns/100ps

module timer_sva (
    input logic       seq,
    input logic       reset,
    input logic [7:0] paddr_low,
    input logic       psel,
    input logic       penable,
    input logic       pwrite,
    input logic       strobe_any,
    input logic       wdata_bit,
    input logic       pready,
    input logic       pause_req,
    input logic       pause_ack,
    input logic       irq
);
    logic ier_model;

    // IER as seen from completed APB writes
    always_ff @(posedge seq) begin
        if (reset) begin
            ier_model <= 1'b0;
        end else if (psel && penable && pready && pwrite && strobe_any
                     && (paddr_low == timer_reg_pkg::IER_OFFSET)) begin
            ier_model <= wdata_bit;
        end
    end

    // Access cycle is the one right after a setup cycle
    pready_in_access: assert property (@(posedge seq) disable iff (reset)
        pready |-> (psel && penable && $past(psel && !penable)))
        else $error("pready high outside an access cycle");

    penable_after_setup: assert property (@(posedge seq) disable iff (reset)
        $rose(penable) |-> $past(psel && !penable))
        else $error("penable rose without a setup cycle");

    ack_needs_request: assert property (@(posedge seq) disable iff (reset)
        $rose(pause_ack) |-> $past(pause_req))
        else $error("pause_ack rose without pause_req");

    // irq is registered, so it follows IER one cycle late
    irq_masked: assert property (@(posedge seq) disable iff (reset)
        irq |-> $past(ier_model))
        else $error("irq high while IER is 0");

endmodule

/* sim/timer_tb.sv */
`timescale 1ns/100ps

module timer_tb;

    localparam int DATA_WIDTH  = 32;
    localparam int ADDR_WIDTH  = 32;
    localparam int APB_TIMEOUT = 16;

    logic        seq;
    logic        reset;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        pause_req;
    logic        pause_ack;
    logic        irq;

    // Shadow copies of the register file
    logic [31:0] sh_cr;
    logic [31:0] sh_pr;
    logic [31:0] sh_arr;
    logic [31:0] sh_ier;
    int          errors;
    int          checks;

    timer_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_dut (
        .seq       (seq),
        .reset     (reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .irq       (irq)
    );

    bind timer_top timer_sva i_sva (
        .seq        (seq),
        .reset      (reset),
        .paddr_low  (paddr[7:0]),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .strobe_any (|pstrb),
        .wdata_bit  (pwdata[0]),
        .pready     (pready),
        .pause_req  (pause_req),
        .pause_ack  (pause_ack),
        .irq        (irq)
    );

    initial begin
        seq = 1'b0;
        forever #20 seq = ~seq;
    end

    task automatic next_cycle();
        @(posedge seq);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic logic is_register(input logic [7:0] offset);
        return offset == timer_reg_pkg::CR_OFFSET || offset == timer_reg_pkg::PR_OFFSET
            || offset == timer_reg_pkg::VR_OFFSET || offset == timer_reg_pkg::ARR_OFFSET
            || offset == timer_reg_pkg::ER_OFFSET || offset == timer_reg_pkg::IER_OFFSET;
    endfunction

    // One setup cycle, then access until pready with a mid-cycle sample
    task automatic apb_transfer(input logic write, input logic [7:0] offset,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic slverr);
        int waited;
        waited  = 0;
        paddr   = {24'h0, offset};
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;
        @(negedge seq);
        while (!pready && waited < APB_TIMEOUT) begin
            @(negedge seq);
            waited++;
        end
        if (!pready) begin
            $display("Error: no pready within %0d cycles at offset %h", APB_TIMEOUT, offset);
            errors++;
        end
        rdata  = prdata;
        slverr = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] offset, input logic [31:0] data);
        logic [31:0] unused_data;
        logic        slverr;
        apb_transfer(1'b1, offset, data, unused_data, slverr);
        check_value("write pslverr", {31'b0, !is_register(offset)}, {31'b0, slverr});
        case (offset)
            timer_reg_pkg::CR_OFFSET:  sh_cr = {31'b0, data[0]};
            timer_reg_pkg::PR_OFFSET:  sh_pr = data;
            timer_reg_pkg::ARR_OFFSET: sh_arr = data;
            timer_reg_pkg::IER_OFFSET: sh_ier = {31'b0, data[0]};
            default: ;
        endcase
    endtask

    task automatic reg_read(input logic [7:0] offset, output logic [31:0] data);
        logic slverr;
        apb_transfer(1'b0, offset, 32'h0, data, slverr);
        check_value("read pslverr", {31'b0, !is_register(offset)}, {31'b0, slverr});
    endtask

    task automatic wait_irq(input logic level, input int limit, output int cycles);
        cycles = 0;
        while (irq !== level && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (irq !== level) begin
            $display("Error: irq did not reach %0b within %0d cycles", level, limit);
            errors++;
        end
    endtask

    task automatic wait_pause_ack(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (pause_ack !== level && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (pause_ack !== level) begin
            $display("Error: pause_ack did not reach %0b within %0d cycles", level, limit);
            errors++;
        end
    endtask

    // Stop, clear events, program and enable
    task automatic start_run(input logic [31:0] start, input logic [31:0] reload,
                             input logic [31:0] prescale, input logic ier);
        reg_write(timer_reg_pkg::CR_OFFSET, 32'h0);
        reg_write(timer_reg_pkg::ER_OFFSET, 32'h1);
        reg_write(timer_reg_pkg::IER_OFFSET, {31'b0, ier});
        reg_write(timer_reg_pkg::PR_OFFSET, prescale);
        reg_write(timer_reg_pkg::ARR_OFFSET, reload);
        reg_write(timer_reg_pkg::VR_OFFSET, start);
        reg_write(timer_reg_pkg::CR_OFFSET, 32'h1);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] paused_value;
        logic [7:0]  offset;
        logic        err;
        logic        masked_ok;
        int unsigned start;
        int unsigned reload;
        int unsigned presc;
        int unsigned span;
        int unsigned repeats;
        int          cycles;
        void'($urandom(32'h4a3af1a4));
        errors    = 0;
        checks    = 0;
        reset     = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pstrb     = '1;
        pause_req = 1'b0;
        sh_cr     = 32'h0;
        sh_pr     = 32'h1;
        sh_arr    = 32'hFFFF_FFFF;
        sh_ier    = 32'h0;
        repeat (8) @(posedge seq);
        #2;
        reset = 1'b0;
        check_value("reset pause_ack", 32'h0, {31'b0, pause_ack});
        check_value("reset irq", 32'h0, {31'b0, irq});

        // Register round trip
        for (int i = 0; i < 4; i++) begin
            reg_write(timer_reg_pkg::PR_OFFSET, $urandom);
            reg_write(timer_reg_pkg::ARR_OFFSET, $urandom);
            reg_write(timer_reg_pkg::IER_OFFSET, $urandom);
            reg_read(timer_reg_pkg::PR_OFFSET, rd);
            check_value("round trip PR", sh_pr, rd);
            reg_read(timer_reg_pkg::ARR_OFFSET, rd);
            check_value("round trip ARR", sh_arr, rd);
            reg_read(timer_reg_pkg::IER_OFFSET, rd);
            check_value("round trip IER", sh_ier, rd);
        end
        reg_read(timer_reg_pkg::CR_OFFSET, rd);
        check_value("round trip CR", sh_cr, rd);

        // Unmapped offsets
        for (int i = 0; i < 8; i++) begin
            offset = 8'($urandom_range(6, 63) << 2);
            apb_transfer(1'b1, offset, $urandom, rd, err);
            check_value("unmapped write pslverr", 32'h1, {31'b0, err});
            apb_transfer(1'b0, offset, 32'h0, rd, err);
            check_value("unmapped read pslverr", 32'h1, {31'b0, err});
        end
        reg_read(timer_reg_pkg::CR_OFFSET, rd);
        check_value("CR after unmapped", sh_cr, rd);
        reg_read(timer_reg_pkg::PR_OFFSET, rd);
        check_value("PR after unmapped", sh_pr, rd);
        reg_read(timer_reg_pkg::ARR_OFFSET, rd);
        check_value("ARR after unmapped", sh_arr, rd);
        reg_read(timer_reg_pkg::IER_OFFSET, rd);
        check_value("IER after unmapped", sh_ier, rd);

        // Counting to overflow
        for (int trial = 0; trial < 10; trial++) begin
            reload = $urandom_range(10, 60);
            start  = $urandom_range(0, reload - 10);
            presc  = $urandom_range(1, 4);
            span   = reload - start + 1;
            start_run(start, reload, presc, 1'b1);
            wait_irq(1'b1, span * presc + 4, cycles);
            checks++;
            if (cycles < int'((span - 1) * presc)) begin
                $display("Fail overflow timing: expected at least %0d cycles, actual %0d",
                         (span - 1) * presc, cycles);
                errors++;
            end
            reg_read(timer_reg_pkg::ER_OFFSET, rd);
            check_value("ER after overflow", 32'h1, rd);
        end

        // Clear and repeat on the last run
        repeats = $urandom_range(0, 5);
        for (int i = 0; i < int'(repeats); i++) begin
            reg_write(timer_reg_pkg::ER_OFFSET, 32'h1);
            wait_irq(1'b0, 3, cycles);
            wait_irq(1'b1, (reload + 1) * presc + 4, cycles);
        end

        // Masking
        reload = $urandom_range(10, 60);
        start  = $urandom_range(0, reload - 10);
        presc  = $urandom_range(1, 4);
        span   = reload - start + 1;
        start_run(start, reload, presc, 1'b0);
        masked_ok = 1'b1;
        for (int i = 0; i < int'(span * presc + 4); i++) begin
            next_cycle();
            if (irq !== 1'b0) masked_ok = 1'b0;
        end
        check_value("masked irq", 32'h0, {31'b0, !masked_ok});
        reg_read(timer_reg_pkg::ER_OFFSET, rd);
        check_value("masked ER", 32'h1, rd);

        // Pause
        start_run(32'h0, 32'h0000_FFFF, 32'h1, 1'b0);
        repeat (5) next_cycle();
        pause_req = 1'b1;
        wait_pause_ack(1'b1, 8);
        reg_read(timer_reg_pkg::VR_OFFSET, paused_value);
        repeat (6) next_cycle();
        reg_read(timer_reg_pkg::VR_OFFSET, rd);
        check_value("VR frozen in pause", paused_value, rd);
        pause_req = 1'b0;
        wait_pause_ack(1'b0, 8);
        repeat (4) next_cycle();
        reg_read(timer_reg_pkg::VR_OFFSET, rd);
        checks++;
        if (rd === paused_value) begin
            $display("Fail VR after resume: expected other than %h, actual %h",
                     paused_value, rd);
            errors++;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
logic/timer_types_pkg.sv
logic/timer_reg_pkg.sv
logic/timer_cfg_if.sv
logic/timer_prescaler.sv
logic/timer_counter.sv
logic/timer_events.sv
logic/timer_regs.sv
logic/timer_top.sv
sim/timer_sva.sv
sim/timer_tb.sv
